// ==== hw/lspUpdate_params.svh ====
`ifndef LSP_UPDATE_PARAMS_SVH
`define LSP_UPDATE_PARAMS_SVH

//////////////////////////////
// Scratch memory geometry
//////////////////////////////

// Word address width, 2048 words
`define LSP_ADDR_W 11
// One Q15 sample in the low half of each word
`define LSP_DATA_W 32
`define LSP_MEM_DEPTH 2048

//////////////////////////////
// G.729 LSP history layout
//////////////////////////////

// Words per LSF vector
`define LSP_M 10
// Previous frames kept for the MA predictor
`define LSP_MA_NP 4

`endif

// ==== hw/lspPkg.sv ====
`default_nettype none
`include "lspUpdate_params.svh"

package lspPkg;

	//////////////////////////////
	// Memory port request
	//////////////////////////////

	// One request per cycle, host or engine
	typedef struct packed {
		logic [`LSP_ADDR_W-1:0] readAddr;
		logic [`LSP_ADDR_W-1:0] writeAddr;
		logic [`LSP_DATA_W-1:0] writeData;
		logic writeEn;
	} memReq_t;

	//////////////////////////////
	// Control encodings
	//////////////////////////////

	// History update FSM states
	typedef enum logic [3:0] {
		IDLE,
		FRAME_SETUP,
		READ,
		WRITE,
		NEXT,
		NEW_SETUP,
		NEW_READ,
		NEW_WRITE,
		FINISH
	} fsmState_e;

	// Address generator commands
	typedef enum logic [2:0] {
		AG_HOLD,
		AG_LOAD_SHIFT,
		AG_NEXT_FRAME,
		AG_LOAD_NEW,
		AG_STEP
	} agOp_e;

endpackage

`default_nettype wire

// ==== hw/scratchMemoryController.sv ====
`default_nettype none
`include "lspUpdate_params.svh"

module scratchMemoryController
(
	input wire logic clk,
	// High gives the host the memory
	input wire logic hostSel,
	input wire lspPkg::memReq_t hostReq,
	input wire lspPkg::memReq_t engineReq,
	output logic [`LSP_DATA_W-1:0] readData
);

	//////////////////////////////
	// Port select
	//////////////////////////////

	// Request seen by the array this cycle
	lspPkg::memReq_t selReq;

	always_comb
	begin
		if (hostSel)
		begin
			selReq = hostReq;
		end
		else
		begin
			selReq = engineReq;
		end
	end

	//////////////////////////////
	// Storage
	//////////////////////////////

	// Single clock, one write and one read port
	logic [`LSP_DATA_W-1:0] mem [0:`LSP_MEM_DEPTH-1];

	// Write on the selected enable
	always_ff @(posedge clk)
	begin
		if (selReq.writeEn)
		begin
			mem[selReq.writeAddr] <= selReq.writeData;
		end
	end

	// Registered read, one cycle of latency
	// Same-address write returns the old word
	always_ff @(posedge clk)
	begin
		readData <= mem[selReq.readAddr];
	end

endmodule

`default_nettype wire

// ==== hw/lspAddrGen.sv ====
`default_nettype none
`include "lspUpdate_params.svh"

module lspAddrGen
(
	input wire logic clk,
	input wire logic rst,
	input wire lspPkg::agOp_e agOp,
	// Base of the new quantized vector
	input wire logic [`LSP_ADDR_W-1:0] lspEleAddr,
	// Base of history frame 0
	input wire logic [`LSP_ADDR_W-1:0] freqPrevAddr,
	output logic [`LSP_ADDR_W-1:0] srcAddr,
	output logic [`LSP_ADDR_W-1:0] dstAddr,
	output logic elemLast,
	output logic frameLast
);

	//////////////////////////////
	// Geometry constants
	//////////////////////////////

	localparam int ELEM_W = $clog2(`LSP_M);
	localparam int FRAME_W = $clog2(`LSP_MA_NP);

	// One frame in address units
	localparam logic [`LSP_ADDR_W-1:0] FRAME_WORDS = `LSP_ADDR_W'(`LSP_M);
	// Offset of the oldest kept frame
	localparam logic [`LSP_ADDR_W-1:0] TOP_OFFSET =
		`LSP_ADDR_W'((`LSP_MA_NP - 1) * `LSP_M);
	localparam logic [ELEM_W-1:0] ELEM_END = ELEM_W'(`LSP_M - 1);
	localparam logic [FRAME_W-1:0] FRAME_TOP = FRAME_W'(`LSP_MA_NP - 1);
	// Last shift target is frame 1
	// Frame 0 takes the new vector instead
	localparam logic [FRAME_W-1:0] FRAME_END = FRAME_W'(1);

	//////////////////////////////
	// Pointer and counter state
	//////////////////////////////

	logic [`LSP_ADDR_W-1:0] dstBase;
	logic [`LSP_ADDR_W-1:0] srcBase;
	logic [ELEM_W-1:0] elemCnt;
	// Index of the destination frame
	logic [FRAME_W-1:0] frameCnt;
	// High while shifting history and low during the new-vector copy
	logic shiftMode;

	// Frame bases for the copy in progress
	always_ff @(posedge clk)
	begin
		case (agOp)
			lspPkg::AG_LOAD_SHIFT: dstBase <= freqPrevAddr + TOP_OFFSET;
			lspPkg::AG_NEXT_FRAME: dstBase <= dstBase - FRAME_WORDS;
			lspPkg::AG_LOAD_NEW:
			begin
				srcBase <= lspEleAddr;
				dstBase <= freqPrevAddr;
			end
			default: ;
		endcase
	end

	// Counters and mode
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			elemCnt <= '0;
			frameCnt <= '0;
			shiftMode <= 1'b0;
		end
		else
		begin
			case (agOp)
				lspPkg::AG_LOAD_SHIFT:
				begin
					elemCnt <= '0;
					frameCnt <= FRAME_TOP;
					shiftMode <= 1'b1;
				end
				lspPkg::AG_NEXT_FRAME:
				begin
					elemCnt <= '0;
					frameCnt <= frameCnt - 1'b1;
				end
				lspPkg::AG_LOAD_NEW:
				begin
					elemCnt <= '0;
					shiftMode <= 1'b0;
				end
				lspPkg::AG_STEP: elemCnt <= elemCnt + 1'b1;
				default: ;
			endcase
		end
	end

	//////////////////////////////
	// Address outputs
	//////////////////////////////

	logic [`LSP_ADDR_W-1:0] elemOffset;

	always_comb
	begin
		elemOffset = `LSP_ADDR_W'(elemCnt);
		dstAddr = dstBase + elemOffset;
		// Shift reads the frame just below the destination
		if (shiftMode)
		begin
			srcAddr = dstBase - FRAME_WORDS + elemOffset;
		end
		else
		begin
			srcAddr = srcBase + elemOffset;
		end
		elemLast = (elemCnt == ELEM_END);
		frameLast = (frameCnt == FRAME_END);
	end

endmodule

`default_nettype wire

// ==== hw/lspPrevUpdateFsm.sv ====
`default_nettype none
`include "lspUpdate_params.svh"

module lspPrevUpdateFsm
(
	input wire logic clk,
	input wire logic rst,
	// Job request, sampled in IDLE only
	input wire logic start,
	// Word read in the previous cycle
	input wire logic [`LSP_DATA_W-1:0] readData,
	// Addresses from the address generator
	input wire logic [`LSP_ADDR_W-1:0] srcAddr,
	input wire logic [`LSP_ADDR_W-1:0] dstAddr,
	input wire logic elemLast,
	input wire logic frameLast,
	output lspPkg::agOp_e agOp,
	output lspPkg::memReq_t engineReq,
	// One-cycle pulse at the end of the job
	output logic done
);

	//////////////////////////////
	// State register
	//////////////////////////////

	lspPkg::fsmState_e state;
	lspPkg::fsmState_e nextState;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= lspPkg::IDLE;
		end
		else
		begin
			state <= nextState;
		end
	end

	//////////////////////////////
	// Sequencing
	//////////////////////////////

	// Each copied word takes a READ and a WRITE cycle
	// Address generator holds during READ so WRITE sees the same pair
	always_comb
	begin
		nextState = state;
		agOp = lspPkg::AG_HOLD;
		case (state)
			lspPkg::IDLE:
			begin
				// Start while busy never reaches here
				if (start)
				begin
					nextState = lspPkg::FRAME_SETUP;
				end
			end
			lspPkg::FRAME_SETUP:
			begin
				// Point at frame 3, source frame 2
				agOp = lspPkg::AG_LOAD_SHIFT;
				nextState = lspPkg::READ;
			end
			lspPkg::READ:
			begin
				nextState = lspPkg::WRITE;
			end
			lspPkg::WRITE:
			begin
				if (elemLast)
				begin
					nextState = lspPkg::NEXT;
				end
				else
				begin
					agOp = lspPkg::AG_STEP;
					nextState = lspPkg::READ;
				end
			end
			lspPkg::NEXT:
			begin
				// Frame 1 done means the shift is finished
				if (frameLast)
				begin
					nextState = lspPkg::NEW_SETUP;
				end
				else
				begin
					agOp = lspPkg::AG_NEXT_FRAME;
					nextState = lspPkg::READ;
				end
			end
			lspPkg::NEW_SETUP:
			begin
				// New vector into frame 0
				agOp = lspPkg::AG_LOAD_NEW;
				nextState = lspPkg::NEW_READ;
			end
			lspPkg::NEW_READ:
			begin
				nextState = lspPkg::NEW_WRITE;
			end
			lspPkg::NEW_WRITE:
			begin
				if (elemLast)
				begin
					nextState = lspPkg::FINISH;
				end
				else
				begin
					agOp = lspPkg::AG_STEP;
					nextState = lspPkg::NEW_READ;
				end
			end
			lspPkg::FINISH:
			begin
				nextState = lspPkg::IDLE;
			end
			default:
			begin
				nextState = lspPkg::IDLE;
			end
		endcase
	end

	//////////////////////////////
	// Engine memory port
	//////////////////////////////

	// Read address always live, write only in the two write states
	always_comb
	begin
		engineReq.readAddr = srcAddr;
		engineReq.writeAddr = dstAddr;
		engineReq.writeData = readData;
		engineReq.writeEn = (state == lspPkg::WRITE) || (state == lspPkg::NEW_WRITE);
	end

	assign done = (state == lspPkg::FINISH);

endmodule

`default_nettype wire

// ==== hw/lspPrevUpdatePipe.sv ====
`default_nettype none
`include "lspUpdate_params.svh"

module lspPrevUpdatePipe
(
	input wire logic clk,
	input wire logic rst,
	input wire logic start,
	input wire logic [`LSP_ADDR_W-1:0] lspEleAddr,
	input wire logic [`LSP_ADDR_W-1:0] freqPrevAddr,
	// Host access, only while the engine is idle
	input wire logic hostSel,
	input wire lspPkg::memReq_t hostReq,
	output logic [`LSP_DATA_W-1:0] readData,
	output logic done
);

	//////////////////////////////
	// Internal wiring
	//////////////////////////////

	lspPkg::agOp_e agOp;
	lspPkg::memReq_t engineReq;
	logic [`LSP_ADDR_W-1:0] srcAddr;
	logic [`LSP_ADDR_W-1:0] dstAddr;
	logic elemLast;
	logic frameLast;

	// Memory shared by host and engine
	scratchMemoryController scratchMemoryController_i (
		.clk(clk),
		.hostSel(hostSel),
		.hostReq(hostReq),
		.engineReq(engineReq),
		.readData(readData)
	);

	// Pointers and counters
	lspAddrGen lspAddrGen_i (
		.clk(clk),
		.rst(rst),
		.agOp(agOp),
		.lspEleAddr(lspEleAddr),
		.freqPrevAddr(freqPrevAddr),
		.srcAddr(srcAddr),
		.dstAddr(dstAddr),
		.elemLast(elemLast),
		.frameLast(frameLast)
	);

	// Sequencer
	lspPrevUpdateFsm lspPrevUpdateFsm_i (
		.clk(clk),
		.rst(rst),
		.start(start),
		.readData(readData),
		.srcAddr(srcAddr),
		.dstAddr(dstAddr),
		.elemLast(elemLast),
		.frameLast(frameLast),
		.agOp(agOp),
		.engineReq(engineReq),
		.done(done)
	);

endmodule

`default_nettype wire

// ==== tb/lspPrevUpdateTb.sv ====
`default_nettype none
`include "lspUpdate_params.svh"

module lspPrevUpdateTb;

	//////////////////////////////
	// Constants and signals
	//////////////////////////////

	localparam int CLK_PERIOD = 100;
	localparam int DRIVE_DELAY = 10;
	localparam int RESET_CYCLES = 8;
	localparam int MAX_TESTS = 16;
	// Budget per test and fixed slack in cycles
	localparam int CYCLES_PER_TEST = 200;
	localparam int CYCLES_SLACK = 1000;
	localparam int HIST_WORDS = `LSP_M * `LSP_MA_NP;

	logic clk;
	logic rst;
	logic start;
	logic [`LSP_ADDR_W-1:0] lspEleAddr;
	logic [`LSP_ADDR_W-1:0] freqPrevAddr;
	logic hostSel;
	lspPkg::memReq_t hostReq;
	logic [`LSP_DATA_W-1:0] readData;
	logic done;

	// Test table from the input file
	string testName [0:MAX_TESTS-1];
	logic [`LSP_ADDR_W-1:0] testFreqPrev [0:MAX_TESTS-1];
	logic [`LSP_ADDR_W-1:0] testLspEle [0:MAX_TESTS-1];
	logic [31:0] testSeed [0:MAX_TESTS-1];
	int testRuns [0:MAX_TESTS-1];
	int numTests;
	logic tableReady;

	// Reference copy of the scratch memory
	logic [`LSP_DATA_W-1:0] shadow [0:`LSP_MEM_DEPTH-1];

	int errorCount;
	int checkCount;
	int doneCount;
	int expectedDone;
	int unsigned seedVal;

	lspPrevUpdatePipe lspPrevUpdatePipe_i (
		.clk(clk),
		.rst(rst),
		.start(start),
		.lspEleAddr(lspEleAddr),
		.freqPrevAddr(freqPrevAddr),
		.hostSel(hostSel),
		.hostReq(hostReq),
		.readData(readData),
		.done(done)
	);

	initial
	begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// Count done pulses mid-cycle
	always @(negedge clk)
	begin
		if (done === 1'b1)
		begin
			doneCount++;
		end
	end

	//////////////////////////////
	// Helpers
	//////////////////////////////

	task automatic checkValue(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		checkCount++;
		if (actual !== expected)
		begin
			$display("Error %s: expected %h, actual %h", name, expected, actual);
			errorCount++;
		end
	endtask

	// Seed mixed with the full address
	function automatic logic [31:0] patternWord(input logic [31:0] seed,
		input logic [`LSP_ADDR_W-1:0] addr);
		patternWord = seed ^ (32'(addr) * 32'h9e37_79b9);
	endfunction

	task automatic readInputFile();
		int fd;
		int code;
		string tok;
		logic [8*128-1:0] restOfLine;
		logic eof;
		fd = $fopen("tb/lspPrevUpdate_input.txt", "r");
		eof = 1'b0;
		if (fd == 0)
		begin
			$display("Could not open the test vector file");
			errorCount++;
			eof = 1'b1;
		end
		while (!eof)
		begin
			code = $fscanf(fd, "%s", tok);
			if (code != 1)
			begin
				eof = 1'b1;
			end
			else if (tok == "//")
			begin
				// Column description line
				code = $fgets(restOfLine, fd);
			end
			else if (numTests < MAX_TESTS)
			begin
				testName[numTests] = tok;
				code = $fscanf(fd, "%h %h %h %d", testFreqPrev[numTests],
					testLspEle[numTests], testSeed[numTests], testRuns[numTests]);
				numTests++;
			end
		end
		if (fd != 0)
		begin
			$fclose(fd);
		end
	endtask

	// Host write lands at the next rising edge
	task automatic writeWord(input logic [`LSP_ADDR_W-1:0] addr, input logic [31:0] data);
		@(posedge clk);
		#DRIVE_DELAY;
		hostReq.writeAddr = addr;
		hostReq.writeData = data;
		hostReq.writeEn = 1'b1;
	endtask

	// Host read with one cycle of latency
	task automatic readWord(input logic [`LSP_ADDR_W-1:0] addr, output logic [31:0] data);
		@(posedge clk);
		#DRIVE_DELAY;
		hostReq.writeEn = 1'b0;
		hostReq.readAddr = addr;
		@(posedge clk);
		@(negedge clk);
		data = readData;
	endtask

	//////////////////////////////
	// Test steps
	//////////////////////////////

	task automatic loadTest(input int idx);
		logic [`LSP_ADDR_W-1:0] fp;
		logic [`LSP_ADDR_W-1:0] le;
		logic [`LSP_ADDR_W-1:0] a;
		int e;
		fp = testFreqPrev[idx];
		le = testLspEle[idx];
		for (e = 0; e < HIST_WORDS; e++)
		begin
			a = fp + e;
			shadow[a] = patternWord(testSeed[idx], a);
			writeWord(a, shadow[a]);
		end
		for (e = 0; e < `LSP_M; e++)
		begin
			a = le + e;
			shadow[a] = patternWord(testSeed[idx], a);
			writeWord(a, shadow[a]);
		end
		// Guard words just outside the history
		a = fp - 1;
		shadow[a] = $urandom;
		writeWord(a, shadow[a]);
		a = fp + HIST_WORDS;
		shadow[a] = $urandom;
		writeWord(a, shadow[a]);
		@(posedge clk);
		#DRIVE_DELAY;
		hostReq.writeEn = 1'b0;
	endtask

	// Reference model drops the oldest frame and puts the new vector in frame 0
	task automatic applyShift(input logic [`LSP_ADDR_W-1:0] fp,
		input logic [`LSP_ADDR_W-1:0] le);
		int k;
		int e;
		for (k = `LSP_MA_NP - 1; k >= 1; k--)
		begin
			for (e = 0; e < `LSP_M; e++)
			begin
				shadow[fp + k * `LSP_M + e] = shadow[fp + (k - 1) * `LSP_M + e];
			end
		end
		for (e = 0; e < `LSP_M; e++)
		begin
			shadow[fp + e] = shadow[le + e];
		end
	endtask

	task automatic runEngine(input int idx);
		@(posedge clk);
		#DRIVE_DELAY;
		hostSel = 1'b0;
		freqPrevAddr = testFreqPrev[idx];
		lspEleAddr = testLspEle[idx];
		start = 1'b1;
		@(posedge clk);
		#DRIVE_DELAY;
		start = 1'b0;
		// Extra start while busy gives no extra done
		repeat (4) @(posedge clk);
		#DRIVE_DELAY;
		start = 1'b1;
		@(posedge clk);
		#DRIVE_DELAY;
		start = 1'b0;
		@(negedge clk);
		while (done !== 1'b1)
		begin
			@(negedge clk);
		end
		expectedDone++;
		applyShift(testFreqPrev[idx], testLspEle[idx]);
		repeat (3) @(negedge clk);
		checkValue($sformatf("%s done count", testName[idx]), expectedDone, doneCount);
	endtask

	task automatic checkResults(input int idx);
		logic [`LSP_ADDR_W-1:0] a;
		logic [31:0] actual;
		int e;
		@(posedge clk);
		#DRIVE_DELAY;
		hostSel = 1'b1;
		// Guards and history first, then the new vector source
		for (e = -1; e <= HIST_WORDS; e++)
		begin
			a = testFreqPrev[idx] + e;
			readWord(a, actual);
			checkValue($sformatf("%s addr %0h", testName[idx], a), shadow[a], actual);
		end
		for (e = 0; e < `LSP_M; e++)
		begin
			a = testLspEle[idx] + e;
			readWord(a, actual);
			checkValue($sformatf("%s src %0h", testName[idx], a), shadow[a], actual);
		end
	endtask

	//////////////////////////////
	// Watchdog and main sequence
	//////////////////////////////

	initial
	begin
		wait (tableReady === 1'b1);
		#((numTests * CYCLES_PER_TEST + CYCLES_SLACK) * CLK_PERIOD);
		$display("Watchdog expired, done never arrived");
		errorCount++;
		$display("Checks run %0d, errors %0d", checkCount, errorCount);
		$display("Done: errors found");
		$finish;
	end

	initial
	begin
		seedVal = $urandom(32'hdbcd_7489);
		rst = 1'b1;
		start = 1'b0;
		hostSel = 1'b1;
		hostReq = '0;
		lspEleAddr = '0;
		freqPrevAddr = '0;
		errorCount = 0;
		checkCount = 0;
		doneCount = 0;
		expectedDone = 0;
		numTests = 0;
		tableReady = 1'b0;
		readInputFile();
		tableReady = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		#DRIVE_DELAY;
		rst = 1'b0;
		@(negedge clk);
		checkValue("reset done", 32'd0, 32'(done));
		if (numTests == 0)
		begin
			$display("No tests were read from the test vector file");
			errorCount++;
		end
		for (int i = 0; i < numTests; i++)
		begin
			loadTest(i);
			// Back-to-back runs with no reload in between
			for (int r = 0; r < testRuns[i]; r++)
			begin
				runEngine(i);
			end
			checkResults(i);
		end
		// A start taken while busy would show up here as a late done
		checkValue("final done count", expectedDone, doneCount);
		$display("Checks run %0d, errors %0d", checkCount, errorCount);
		if (errorCount == 0)
		begin
			$display("Done: no errors");
		end
		else
		begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+hw
hw/lspPkg.sv
hw/scratchMemoryController.sv
hw/lspAddrGen.sv
hw/lspPrevUpdateFsm.sv
hw/lspPrevUpdatePipe.sv
tb/lspPrevUpdateTb.sv

// ==== tb/lspPrevUpdate_input.txt ====
// name freqPrevAddr lspEleAddr dataSeed runs
// addresses and seed in hex, runs in decimal
basicLow 010 080 1a2b3c4d 1
newBelowHist 200 100 5eedf00d 1
twoRunsMid 400 460 c0ffee01 2
topOfMemory 7d6 7a0 deadbeef 1
adjacentNew 300 329 12345678 2
lowGuardEdge 100 0f5 87654321 1
